/* sim.f */
hw/busPkg.sv
hw/dispPkg.sv
hw/glyphEncoder.sv
hw/displayCtrl.sv
hw/digitBank.sv
hw/scanMux.sv
hw/sevenSegPeriph.sv
test/sevenSegPeriph_checker.sv
test/sevenSegPeriph_tb.sv

/* run.sh */
#!/bin/sh
# compile and run the seven-segment peripheral testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log
TOP=sevenSegPeriph_tb

echo "compiling $TOP"
verilator --binary --timing --assert -Wno-fatal \
    --top-module "$TOP" --Mdir "$BUILD_DIR" -f sim.f
status=$?
if [ $status -ne 0 ]; then
    echo "compile failed with status $status"
    exit 1
fi

echo "running $TOP"
"./$BUILD_DIR/V$TOP" +verilator+error+limit+1000 > "$LOG_FILE" 2>&1
status=$?
cat "$LOG_FILE"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# the log decides the result
if grep -qx "TESTBENCH PASSED" "$LOG_FILE"; then
    echo "result: pass"
    exit 0
fi

echo "result: fail"
exit 1

/* test/sevenSegPeriph_tb.sv */
// directed testbench for the seven-segment peripheral; simulation top with reference model
`timescale 1ns/1ps
`default_nettype none

module sevenSegPeriph_tb;
    import busPkg::*;
    import dispPkg::*;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 3;
    localparam int NUM_EXTRA    = 4;
    localparam int IGNORED_RAND = 32;

    // cycle budget of each test, summed for the watchdog
    localparam int RESET_BUDGET   = RESET_CYCLES + 2;
    localparam int GLYPH_BUDGET   = NUM_DIGITS * (GLYPH_COUNT + NUM_EXTRA + 1);
    localparam int RAW_BUDGET     = NUM_DIGITS + 6;
    localparam int BLANK_BUDGET   = 4;
    localparam int SCAN_BUDGET    = NUM_DIGITS * SCAN_DIV + 2 + 4;
    localparam int IGNORED_BUDGET = IGNORED_RAND + 20;
    localparam int MARGIN_CYCLES  = 100;
    localparam int TOTAL_CYCLES   = RESET_BUDGET + GLYPH_BUDGET + RAW_BUDGET + BLANK_BUDGET
                                  + SCAN_BUDGET + IGNORED_BUDGET + MARGIN_CYCLES;

    logic        clk = 1'b0;
    logic        nrst;
    busWrite_t   busIn;
    digitArray_t digits;
    segPattern_t scanSeg;
    logic [7:0]  scanAnode;

    // reference model state
    digitArray_t expStored;
    logic [7:0]  expMask;
    logic        expRaw;

    integer seed;
    int     errCount;
    int     checkCount;
    int     testCount;

    sevenSegPeriph DUT (
        .clk       (clk),
        .nrst      (nrst),
        .busIn     (busIn),
        .digits    (digits),
        .scanSeg   (scanSeg),
        .scanAnode (scanAnode)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // segment letters per glyph, a is bit 0 up to g at bit 6
    function automatic segPattern_t glyphRef(input logic [7:0] value);
        string       lit;
        segPattern_t pat;
        int          bitPos;
        pat = '0;
        case (value)
            8'd0:    lit = "abcdef";
            8'd1:    lit = "bc";
            8'd2:    lit = "abdeg";
            8'd3:    lit = "abcdg";
            8'd4:    lit = "bcfg";
            8'd5:    lit = "acdfg";
            8'd6:    lit = "acdefg";
            8'd7:    lit = "abc";
            8'd8:    lit = "abcdefg";
            8'd9:    lit = "abcdfg";
            8'd10:   lit = "abcefg";
            8'd11:   lit = "cdefg";
            8'd12:   lit = "adef";
            8'd13:   lit = "bcdeg";
            8'd14:   lit = "adefg";
            8'd15:   lit = "aefg";
            // H, U, o, r
            8'd16:   lit = "bcefg";
            8'd17:   lit = "bcdef";
            8'd18:   lit = "cdeg";
            8'd19:   lit = "eg";
            default: lit = "";
        endcase
        for (int i = 0; i < lit.len(); i++) begin
            bitPos = int'(lit[i]) - int'(8'h61);
            pat[bitPos[2:0]] = 1'b1;
        end
        return pat;
    endfunction

    function automatic segPattern_t encodeRef(input logic [7:0] value);
        return expRaw ? value : glyphRef(value);
    endfunction

    // what the parallel outputs should show
    function automatic digitArray_t maskedRef();
        digitArray_t res;
        for (int i = 0; i < NUM_DIGITS; i++) begin
            res[i] = expMask[i] ? '0 : expStored[i];
        end
        return res;
    endfunction

    task automatic checkSeg(input string name, input segPattern_t got, input segPattern_t exp);
        checkCount++;
        if (got !== exp) begin
            errCount++;
            $display("Fail time=%0t signal=%s got=%h expected=%h", $time, name, got, exp);
        end
    endtask

    task automatic checkDigits(input string name, input digitArray_t got, input digitArray_t exp);
        checkCount++;
        if (got !== exp) begin
            errCount++;
            $display("Fail time=%0t signal=%s got=%h expected=%h", $time, name, got, exp);
        end
    endtask

    task automatic checkAnode(input string name, input logic [7:0] got, input logic [7:0] exp);
        checkCount++;
        if (got !== exp) begin
            errCount++;
            $display("Fail time=%0t signal=%s got=%b expected=%b", $time, name, got, exp);
        end
    endtask

    // called at a falling edge, returns at the falling edge after the write
    task automatic busWrite(input logic [15:0] addr, input logic [7:0] data, input logic we);
        busIn.addr        = addr;
        busIn.data        = data;
        busIn.writeEnable = we;
        @(negedge clk);
        busIn.writeEnable = 1'b0;
    endtask

    task automatic writeDigit(input int idx, input logic [7:0] value);
        busWrite(DISP_BASE_ADDR + 16'(idx), value, 1'b1);
        expStored[idx] = encodeRef(value);
    endtask

    task automatic checkQuiet();
        checkDigits("digits", digits, maskedRef());
        checkAnode("scanAnode", scanAnode, '0);
        checkSeg("scanSeg", scanSeg, '0);
    endtask

    task automatic reportTest(input string name, input int startErr);
        testCount++;
        if (errCount == startErr) begin
            $display("test %-14s ok", name);
        end else begin
            $display("test %-14s %0d errors", name, errCount - startErr);
        end
    endtask

    task automatic testReset();
        checkDigits("digits", digits, '0);
        checkSeg("scanSeg", scanSeg, '0);
        checkAnode("scanAnode", scanAnode, '0);
    endtask

    task automatic testGlyphWrites();
        logic [7:0] extras [NUM_EXTRA];
        logic [7:0] value;
        extras = '{8'd20, 8'd37, 8'h80, 8'hFF};
        for (int d = 0; d < NUM_DIGITS; d++) begin
            for (int k = 0; k < GLYPH_COUNT + NUM_EXTRA; k++) begin
                value = (k < NUM_EXTRA) ? extras[k] : 8'(k - NUM_EXTRA);
                writeDigit(d, value);
                checkDigits("digits", digits, maskedRef());
            end
            // leave a distinct glyph on each digit
            writeDigit(d, 8'(d + 10));
            checkDigits("digits", digits, maskedRef());
        end
    endtask

    task automatic testRawMode();
        logic [7:0] value;
        busWrite(DISP_BASE_ADDR + MODE_OFFSET, 8'h01, 1'b1);
        expRaw = 1'b1;
        for (int d = 0; d < NUM_DIGITS; d++) begin
            value = 8'($random(seed));
            writeDigit(d, value);
            checkDigits("digits", digits, maskedRef());
        end
        // decimal point only
        writeDigit(3, 8'h80);
        checkDigits("digits", digits, maskedRef());
        busWrite(DISP_BASE_ADDR + MODE_OFFSET, 8'h00, 1'b1);
        expRaw = 1'b0;
        writeDigit(2, 8'd5);
        checkDigits("digits", digits, maskedRef());
        writeDigit(6, 8'd16);
        checkDigits("digits", digits, maskedRef());
        writeDigit(4, 8'd99);
        checkDigits("digits", digits, maskedRef());
    endtask

    task automatic testBlankMask();
        expMask = 8'b1010_0101;
        busWrite(DISP_BASE_ADDR + BLANK_OFFSET, expMask, 1'b1);
        checkDigits("digits", digits, maskedRef());
        // a hidden digit still takes the write
        writeDigit(0, 8'd8);
        checkDigits("digits", digits, maskedRef());
        expMask = '0;
        busWrite(DISP_BASE_ADDR + BLANK_OFFSET, 8'h00, 1'b1);
        checkDigits("digits", digits, maskedRef());
    endtask

    task automatic testScanning();
        digitArray_t shown;
        int          pos;
        busWrite(DISP_BASE_ADDR + MODE_OFFSET, 8'h02, 1'b1);
        shown = maskedRef();
        for (int j = 0; j < NUM_DIGITS * SCAN_DIV + 2; j++) begin
            if (j == 0) begin
                // scan output is one cycle behind the config
                checkAnode("scanAnode", scanAnode, '0);
                checkSeg("scanSeg", scanSeg, '0);
            end else begin
                pos = ((j - 1) / SCAN_DIV) % NUM_DIGITS;
                checkAnode("scanAnode", scanAnode, 8'(1) << pos);
                checkSeg("scanSeg", scanSeg, shown[pos]);
            end
            @(negedge clk);
        end
        checkDigits("digits", digits, shown);
        busWrite(DISP_BASE_ADDR + MODE_OFFSET, 8'h00, 1'b1);
        @(negedge clk);
        checkAnode("scanAnode", scanAnode, '0);
        checkSeg("scanSeg", scanSeg, '0);
    endtask

    task automatic testIgnoredWrites();
        logic [15:0] addr;
        logic [7:0]  data;
        busWrite(DISP_BASE_ADDR - 16'd1, 8'h03, 1'b1);
        checkQuiet();
        busWrite(DISP_BASE_ADDR + BLANK_OFFSET + 16'd1, 8'hFF, 1'b1);
        checkQuiet();
        for (int n = 0; n < IGNORED_RAND; n++) begin
            addr = 16'($random(seed));
            while (16'(addr - DISP_BASE_ADDR) <= BLANK_OFFSET) begin
                addr = 16'($random(seed));
            end
            data = 8'($random(seed));
            busWrite(addr, data, 1'b1);
            checkQuiet();
        end
        // inside the window, writeEnable low
        for (int off = 0; off <= 9; off++) begin
            busWrite(DISP_BASE_ADDR + 16'(off), 8'hFF, 1'b0);
            checkQuiet();
        end
        @(negedge clk);
        checkQuiet();
        // rawMode must still be clear
        writeDigit(1, 8'd14);
        checkQuiet();
    endtask

    initial begin
        int startErr;
        seed       = 78;
        errCount   = 0;
        checkCount = 0;
        testCount  = 0;
        nrst       = 1'b0;
        busIn      = '0;
        expStored  = '0;
        expMask    = '0;
        expRaw     = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        nrst = 1'b1;
        @(negedge clk);

        startErr = errCount;
        testReset();
        reportTest("reset", startErr);
        startErr = errCount;
        testGlyphWrites();
        reportTest("glyphWrites", startErr);
        startErr = errCount;
        testRawMode();
        reportTest("rawMode", startErr);
        startErr = errCount;
        testBlankMask();
        reportTest("blankMask", startErr);
        startErr = errCount;
        testScanning();
        reportTest("scanning", startErr);
        startErr = errCount;
        testIgnoredWrites();
        reportTest("ignoredWrites", startErr);

        if (DUT.u_checker.assertFails != 0) begin
            $display("checker assertions failed %0d times", DUT.u_checker.assertFails);
            errCount += int'(DUT.u_checker.assertFails);
        end
        $display("tests %0d, checks %0d, errors %0d", testCount, checkCount, errCount);
        if (errCount == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(TOTAL_CYCLES * CLK_PERIOD);
        $display("watchdog expired before the tests finished");
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule : sevenSegPeriph_tb

`default_nettype wire

/* test/sevenSegPeriph_checker.sv */
// concurrent assertions on the seven-segment peripheral, bound into its top level
`timescale 1ns/1ps
`default_nettype none

module sevenSegPeriph_checker (
    input logic                 clk,
    input logic                 nrst,
    input logic                 scanEnable,
    input logic [7:0]           blankMask,
    input logic                 wrEn,
    input dispPkg::digitIdx_t   wrIdx,
    input dispPkg::segPattern_t pattern,
    input dispPkg::digitArray_t digits,
    input logic [7:0]           scanAnode
);
    // number of assertion failures so far
    int unsigned assertFails = 0;

    // at most one anode lit
    anodeOneHot: assert property (@(posedge clk) disable iff (!nrst)
        $onehot0(scanAnode))
    else begin
        assertFails++;
        $error("scanAnode has more than one bit set: %b", scanAnode);
    end

    anodeOffWhenIdle: assert property (@(posedge clk) disable iff (!nrst)
        !scanEnable |=> scanAnode == 8'h00)
    else begin
        assertFails++;
        $error("scanAnode lit one cycle after scanEnable was clear: %b", scanAnode);
    end

    // unmasked digit shows the written pattern one cycle later
    writeLands: assert property (@(posedge clk) disable iff (!nrst)
        (wrEn && !blankMask[wrIdx]) |=> digits[$past(wrIdx)] == $past(pattern))
    else begin
        assertFails++;
        $error("digit write did not reach the digit array");
    end

endmodule : sevenSegPeriph_checker

bind sevenSegPeriph sevenSegPeriph_checker u_checker (
    .clk        (clk),
    .nrst       (nrst),
    .scanEnable (cfg.scanEnable),
    .blankMask  (cfg.blankMask),
    .wrEn       (digWr.wr),
    .wrIdx      (digWr.idx),
    .pattern    (digWr.pattern),
    .digits     (digits),
    .scanAnode  (scanAnode)
);

`default_nettype wire

/* hw/sevenSegPeriph.sv */
// top level of the memory-mapped seven-segment peripheral, parallel and scanned outputs
`timescale 1ns/1ps
`default_nettype none

module sevenSegPeriph (
    input  logic                 clk,
    input  logic                 nrst,
    input  busPkg::busWrite_t    busIn,
    output dispPkg::digitArray_t digits,
    output dispPkg::segPattern_t scanSeg,
    output logic [7:0]           scanAnode
);
    import dispPkg::*;

    // digit write request, index from the decoder and pattern from the encoder
    wire digitWrite_t digWr;

    dispConfig_t cfg;
    digitIdx_t   scanIdx;

    displayCtrl u_displayCtrl (
        .clk        (clk),
        .nrst       (nrst),
        .busIn      (busIn),
        .digitWrEn  (digWr.wr),
        .digitWrIdx (digWr.idx),
        .cfg        (cfg),
        .scanIdx    (scanIdx)
    );

    glyphEncoder u_glyphEncoder (
        .data    (busIn.data),
        .rawMode (cfg.rawMode),
        .pattern (digWr.pattern)
    );

    digitBank u_digitBank (
        .clk       (clk),
        .nrst      (nrst),
        .wrEn      (digWr.wr),
        .wrIdx     (digWr.idx),
        .pattern   (digWr.pattern),
        .blankMask (cfg.blankMask),
        .digits    (digits)
    );

    // scanned output reads the masked parallel patterns
    scanMux u_scanMux (
        .clk        (clk),
        .nrst       (nrst),
        .scanEnable (cfg.scanEnable),
        .scanIdx    (scanIdx),
        .digits     (digits),
        .scanSeg    (scanSeg),
        .scanAnode  (scanAnode)
    );

endmodule : sevenSegPeriph

`default_nettype wire

/* hw/scanMux.sv */
// registered digit select and one-hot anode drive for multiplexed display scanning
`timescale 1ns/1ps
`default_nettype none

module scanMux (
    input  logic                 clk,
    input  logic                 nrst,
    input  logic                 scanEnable,
    input  dispPkg::digitIdx_t   scanIdx,
    input  dispPkg::digitArray_t digits,
    output dispPkg::segPattern_t scanSeg,
    output logic [7:0]           scanAnode
);
    import dispPkg::*;

    // segment and anode are registered together so they always match
    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            scanSeg   <= '0;
            scanAnode <= '0;
        end else if (scanEnable) begin
            scanSeg   <= digits[scanIdx];
            scanAnode <= NUM_DIGITS'(1) << scanIdx;
        end else begin
            // all anodes off while scanning is disabled
            scanSeg   <= '0;
            scanAnode <= '0;
        end
    end

endmodule : scanMux

`default_nettype wire

/* hw/digitBank.sv */
// eight digit pattern registers with per-digit blanking on the parallel outputs
`timescale 1ns/1ps
`default_nettype none

module digitBank (
    input  logic                 clk,
    input  logic                 nrst,
    input  logic                 wrEn,
    input  dispPkg::digitIdx_t   wrIdx,
    input  dispPkg::segPattern_t pattern,
    input  logic [7:0]           blankMask,
    output dispPkg::digitArray_t digits
);
    import dispPkg::*;

    digitArray_t stored;

    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            stored <= '0;
        end else if (wrEn) begin
            stored[wrIdx] <= pattern;
        end
    end

    // blanking only hides a digit, the stored pattern survives
    always_comb begin
        for (int i = 0; i < NUM_DIGITS; i++) begin
            digits[i] = blankMask[i] ? '0 : stored[i];
        end
    end

endmodule : digitBank

`default_nettype wire

/* hw/displayCtrl.sv */
// address decode, mode and blank registers, and scan index sequencing for the display
`timescale 1ns/1ps
`default_nettype none

module displayCtrl (
    input  logic                clk,
    input  logic                nrst,
    input  busPkg::busWrite_t   busIn,
    output logic                digitWrEn,
    output dispPkg::digitIdx_t  digitWrIdx,
    output dispPkg::dispConfig_t cfg,
    output dispPkg::digitIdx_t  scanIdx
);
    import busPkg::*;
    import dispPkg::*;

    localparam int PRESC_W = (SCAN_DIV > 1) ? $clog2(SCAN_DIV) : 1;

    logic [15:0]        offset;
    logic               modeWr;
    logic               blankWr;
    logic [PRESC_W-1:0] prescaler;

    // addresses below the base wrap to large offsets and miss the map
    assign offset = busIn.addr - DISP_BASE_ADDR;

    assign digitWrEn  = busIn.writeEnable && (offset <= DIGIT_OFFSET_LAST);
    assign digitWrIdx = offset[2:0];

    assign modeWr  = busIn.writeEnable && (offset == MODE_OFFSET);
    assign blankWr = busIn.writeEnable && (offset == BLANK_OFFSET);

    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            cfg <= '0;
        end else begin
            if (modeWr) begin
                cfg.rawMode    <= busIn.data[0];
                cfg.scanEnable <= busIn.data[1];
            end
            if (blankWr) begin
                cfg.blankMask <= busIn.data;
            end
        end
    end

    // each digit is held for SCAN_DIV cycles, index wraps 7 to 0
    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            prescaler <= '0;
            scanIdx   <= '0;
        end else if (!cfg.scanEnable) begin
            prescaler <= '0;
            scanIdx   <= '0;
        end else if (prescaler == PRESC_W'(SCAN_DIV - 1)) begin
            prescaler <= '0;
            scanIdx   <= scanIdx + 3'd1;
        end else begin
            prescaler <= prescaler + 1'b1;
        end
    end

endmodule : displayCtrl

`default_nettype wire

/* hw/glyphEncoder.sv */
// combinational byte to segment encoder, glyph table lookup or raw passthrough
`timescale 1ns/1ps
`default_nettype none

module glyphEncoder (
    input  logic [7:0]           data,
    input  logic                 rawMode,
    output dispPkg::segPattern_t pattern
);
    import dispPkg::*;

    segPattern_t glyph;

    // segments gfedcba, decimal point off
    always_comb begin
        glyph = '0;
        if (data < GLYPH_COUNT) begin
            case (data[4:0])
                5'd0:    glyph = 8'b0011_1111;
                5'd1:    glyph = 8'b0000_0110;
                5'd2:    glyph = 8'b0101_1011;
                5'd3:    glyph = 8'b0100_1111;
                5'd4:    glyph = 8'b0110_0110;
                5'd5:    glyph = 8'b0110_1101;
                5'd6:    glyph = 8'b0111_1101;
                5'd7:    glyph = 8'b0000_0111;
                5'd8:    glyph = 8'b0111_1111;
                5'd9:    glyph = 8'b0110_1111;
                5'd10:   glyph = 8'b0111_0111;
                5'd11:   glyph = 8'b0111_1100;
                5'd12:   glyph = 8'b0011_1001;
                5'd13:   glyph = 8'b0101_1110;
                5'd14:   glyph = 8'b0111_1001;
                5'd15:   glyph = 8'b0111_0001;
                // letters after the hex digits
                5'd16:   glyph = 8'b0111_0110;
                5'd17:   glyph = 8'b0011_1110;
                5'd18:   glyph = 8'b0101_1100;
                5'd19:   glyph = 8'b0101_0000;
                default: glyph = '0;
            endcase
        end
    end

    // raw mode drives segments straight from the byte, dp included
    assign pattern = rawMode ? data : glyph;

endmodule : glyphEncoder

`default_nettype wire

/* hw/dispPkg.sv */
// display-side definitions: segment, config and scan types plus display constants
`default_nettype none

package dispPkg;

    localparam int NUM_DIGITS = 8;

    // cycles each digit stays selected during scanning
    localparam int SCAN_DIV = 4;

    // hex 0-F, then H, U, o, r
    localparam int GLYPH_COUNT = 20;

    typedef logic [2:0] digitIdx_t;

    // bit 0 is segment a, bit 6 is segment g, bit 7 is the decimal point
    typedef logic [7:0] segPattern_t;

    typedef segPattern_t [NUM_DIGITS-1:0] digitArray_t;

    // register contents written through the mode and blank offsets
    typedef struct packed {
        logic       rawMode;
        logic       scanEnable;
        logic [7:0] blankMask;
    } dispConfig_t;

    // one digit register update
    typedef struct packed {
        logic        wr;
        digitIdx_t   idx;
        segPattern_t pattern;
    } digitWrite_t;

endpackage : dispPkg

`default_nettype wire

/* hw/busPkg.sv */
// bus-side definitions: write transaction type and the peripheral address map
`default_nettype none

package busPkg;

    // one bus write, sampled at every rising clk
    typedef struct packed {
        logic [15:0] addr;
        logic [7:0]  data;
        logic        writeEnable;
    } busWrite_t;

    // first address of the display register window
    localparam logic [15:0] DISP_BASE_ADDR = 16'h0040;

    // offsets from DISP_BASE_ADDR
    // 0 to 7 are the digit registers
    localparam logic [15:0] DIGIT_OFFSET_LAST = 16'd7;

    // bit 0 rawMode, bit 1 scanEnable
    localparam logic [15:0] MODE_OFFSET = 16'd8;

    // bit i blanks digit i
    localparam logic [15:0] BLANK_OFFSET = 16'd9;

endpackage : busPkg

`default_nettype wire
